// ==== logic/jesd_pkg.sv ====
// Link geometry shared by the loopback design
// Lane and channel counts, sample width and the flat sample layout
// Comma character, lock count and LMFC period
// SYSREF conditioning select codes

`default_nettype none

package jesd_pkg;

  // ********************
  // Link geometry
  // ********************

  localparam int JESD_L = 4;
  localparam int JESD_M = 4;
  localparam int JESD_NP = 16;
  localparam int LANE_OCTETS = 4;
  localparam int LANE_WIDTH = LANE_OCTETS * 8;

  // Samples carried per channel on every beat across all lanes
  localparam int SAMPLES_PER_CHANNEL = (JESD_L * LANE_WIDTH) / (JESD_M * JESD_NP);

  // Channel c, slot s sits at bit (c * SAMPLES_PER_CHANNEL + s) * JESD_NP
  localparam int SAMPLE_BUS_WIDTH = JESD_M * SAMPLES_PER_CHANNEL * JESD_NP;

  // ********************
  // Link control
  // ********************

  // K28.5 octet used for code-group synchronization
  localparam logic [7:0] COMMA_CHAR = 8'hBC;

  // Consecutive all-comma words before a lane counts as locked
  localparam int CGS_LOCK_COUNT = 4;
  localparam int LOCK_CNT_WIDTH = $clog2(CGS_LOCK_COUNT);

  // Beats per local multiframe
  localparam int LMFC_BEATS = 8;
  localparam int LMFC_CNT_WIDTH = $clog2(LMFC_BEATS);

  // SYSREF conditioning, code 3 falls back to direct
  localparam logic [1:0] SYSREF_DIRECT = 2'd0;
  localparam logic [1:0] SYSREF_DELAYED = 2'd1;
  localparam logic [1:0] SYSREF_INVERTED = 2'd2;

endpackage

`default_nettype wire

// ==== logic/sysref_lmfc.sv ====
// SYSREF conditioning (direct, one cycle late or inverted)
// Rising edge detection on the conditioned SYSREF
// LMFC beat counter with a one-cycle boundary pulse

`timescale 1ns/100ps
`default_nettype none

module sysref_lmfc import jesd_pkg::*; (
  input  logic       device_clk,
  input  logic       reset,
  input  logic       sysref,
  input  logic [1:0] sysref_sel,
  output logic       lmfc_edge
);

  logic sysref_d;
  logic sysref_cond;
  logic sysref_prev;
  logic sysref_rise;
  logic [LMFC_CNT_WIDTH-1:0] beat_cnt;

  // One-cycle late copy for the delayed option
  always_ff @(posedge device_clk) begin
    sysref_d <= sysref;
  end

  always_comb begin
    case (sysref_sel)
      SYSREF_DIRECT: sysref_cond = sysref;
      SYSREF_DELAYED: sysref_cond = sysref_d;
      SYSREF_INVERTED: sysref_cond = ~sysref;
      default: sysref_cond = sysref;
    endcase
  end

  // Previous value resets high so a level already high at reset is no edge
  assign sysref_rise = sysref_cond & ~sysref_prev;

  // ********************
  // LMFC counter
  // ********************

  always_ff @(posedge device_clk) begin
    if (reset) begin
      sysref_prev <= 1'b1;
      beat_cnt <= '0;
      lmfc_edge <= 1'b0;
    end else begin
      sysref_prev <= sysref_cond;
      if (sysref_rise) begin
        // Boundary lands on the next cycle; a boundary just emitted swallows it
        beat_cnt <= '0;
        lmfc_edge <= ~lmfc_edge;
      end else begin
        if (beat_cnt == LMFC_CNT_WIDTH'(LMFC_BEATS - 1)) begin
          beat_cnt <= '0;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
        lmfc_edge <= (beat_cnt == LMFC_CNT_WIDTH'(LMFC_BEATS - 1));
      end
    end
  end

  // A realignment never produces back-to-back boundaries
  assert property (@(posedge device_clk) disable iff (reset) lmfc_edge |=> !lmfc_edge)
    else $error("lmfc_edge high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== logic/sample_pattern_gen.sv ====
// Free-running sample source standing in for the DMA path
// Each sample holds its channel number in the top nibble
// and a ramp in the low byte that advances per slot and per beat

`timescale 1ns/100ps
`default_nettype none

module sample_pattern_gen import jesd_pkg::*; (
  input  logic                        device_clk,
  input  logic                        reset,
  output logic [SAMPLE_BUS_WIDTH-1:0] samples
);

  // Only the low byte of the beat count reaches the samples
  logic [7:0] beat_cnt;

  always_ff @(posedge device_clk) begin
    if (reset) begin
      beat_cnt <= '0;
    end else begin
      beat_cnt <= beat_cnt + 8'(SAMPLES_PER_CHANNEL);
    end
  end

  // ********************
  // Sample words
  // ********************

  // Layout is channel, zero padding, then the ramp byte
  always_ff @(posedge device_clk) begin
    for (int c = 0; c < JESD_M; c++) begin
      for (int s = 0; s < SAMPLES_PER_CHANNEL; s++) begin
        samples[(c * SAMPLES_PER_CHANNEL + s) * JESD_NP +: JESD_NP] <= {
          4'(c),
          {(JESD_NP - 12){1'b0}},
          8'(beat_cnt + 8'(s))
        };
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/jesd_tx_transport.sv ====
// Transmit transport layer
// Registers the flat sample vector and packs it into lane words
// following the shared channel and slot layout

`timescale 1ns/100ps
`default_nettype none

module jesd_tx_transport import jesd_pkg::*; (
  input  logic                                device_clk,
  input  logic                                reset,
  input  logic [SAMPLE_BUS_WIDTH-1:0]         samples,
  output logic [JESD_L-1:0][LANE_WIDTH-1:0]   lane_words
);

  // Samples are payload; reset only holds the pipeline stable
  always_ff @(posedge device_clk) begin
    if (reset) begin
      lane_words <= '0;
    end else begin
      for (int c = 0; c < JESD_M; c++) begin
        for (int s = 0; s < SAMPLES_PER_CHANNEL; s++) begin
          // Lowest octet of a lane goes out first, so slot 0 takes the low half
          lane_words[((c * SAMPLES_PER_CHANNEL + s) * JESD_NP) / LANE_WIDTH]
                    [((c * SAMPLES_PER_CHANNEL + s) * JESD_NP) % LANE_WIDTH +: JESD_NP] <=
            samples[(c * SAMPLES_PER_CHANNEL + s) * JESD_NP +: JESD_NP];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/jesd_tx_link.sv ====
// Transmit link layer
// Code-group synchronization with comma words on every lane
// Start of user data aligned to an LMFC boundary
// Fall back to synchronization whenever sync_n drops

`timescale 1ns/100ps
`default_nettype none

module jesd_tx_link import jesd_pkg::*; (
  input  logic                               device_clk,
  input  logic                               reset,
  input  logic [JESD_L-1:0][LANE_WIDTH-1:0]  lane_words,
  input  logic                               lmfc_edge,
  input  logic                               sync_n,
  output logic [JESD_L-1:0][LANE_WIDTH-1:0]  tx_lane_data,
  output logic [JESD_L-1:0][LANE_OCTETS-1:0] tx_lane_k
);

  // Low means CGS, high means DATA
  logic in_data;

  // ********************
  // Link state
  // ********************

  always_ff @(posedge device_clk) begin
    if (reset) begin
      in_data <= 1'b0;
    end else begin
      case (in_data)
        1'b0: begin
          // Receiver locked and a multiframe starts, data leaves next cycle
          if (sync_n && lmfc_edge) begin
            in_data <= 1'b1;
          end
        end
        default: begin
          // A resync request sends the link back to commas at once
          if (!sync_n) begin
            in_data <= 1'b0;
          end
        end
      endcase
    end
  end

  // ********************
  // Lane output mux
  // ********************

  always_comb begin
    for (int l = 0; l < JESD_L; l++) begin
      if (in_data) begin
        tx_lane_data[l] = lane_words[l];
        tx_lane_k[l] = '0;
      end else begin
        tx_lane_data[l] = {LANE_OCTETS{COMMA_CHAR}};
        tx_lane_k[l] = '1;
      end
    end
  end

  // The cycle after a resync request, every octet on every lane is a K character
  assert property (@(posedge device_clk) disable iff (reset) !sync_n |=> (&tx_lane_k))
    else $error("K flags not all set after sync_n low");

endmodule

`default_nettype wire

// ==== logic/jesd_rx_link.sv ====
// Receive link layer
// Per-lane comma counting and lock flags
// sync_n generation from the lock of all lanes
// Detection of the first data beat and registered lane data

`timescale 1ns/100ps
`default_nettype none

module jesd_rx_link import jesd_pkg::*; (
  input  logic                               device_clk,
  input  logic                               reset,
  input  logic                               link_enable,
  input  logic [JESD_L-1:0][LANE_WIDTH-1:0]  rx_lane_data_in,
  input  logic [JESD_L-1:0][LANE_OCTETS-1:0] rx_lane_k_in,
  output logic                               sync_n,
  output logic [JESD_L-1:0][LANE_WIDTH-1:0]  rx_lane_data,
  output logic                               rx_data_start
);

  logic [JESD_L-1:0] lane_comma;
  logic [JESD_L-1:0] lane_lock;
  logic [LOCK_CNT_WIDTH-1:0] comma_cnt [JESD_L];
  logic no_k;
  logic in_data;

  // A lane word counts as a comma only with every octet K28.5 and flagged K
  always_comb begin
    for (int l = 0; l < JESD_L; l++) begin
      lane_comma[l] = (&rx_lane_k_in[l]) &&
                      (rx_lane_data_in[l] == {LANE_OCTETS{COMMA_CHAR}});
    end
  end

  // User data carries no K character on any lane
  assign no_k = ~|rx_lane_k_in;

  // ********************
  // Lock and sync
  // ********************

  always_ff @(posedge device_clk) begin
    if (reset || !link_enable) begin
      // Disabled link drops every lock and keeps requesting sync
      for (int l = 0; l < JESD_L; l++) begin
        comma_cnt[l] <= '0;
      end
      lane_lock <= '0;
      sync_n <= 1'b0;
      in_data <= 1'b0;
      rx_data_start <= 1'b0;
    end else begin
      for (int l = 0; l < JESD_L; l++) begin
        // Once locked a lane stays locked while the link is enabled
        if (!lane_lock[l]) begin
          if (!lane_comma[l]) begin
            comma_cnt[l] <= '0;
          end else if (comma_cnt[l] == LOCK_CNT_WIDTH'(CGS_LOCK_COUNT - 1)) begin
            lane_lock[l] <= 1'b1;
          end else begin
            comma_cnt[l] <= comma_cnt[l] + 1'b1;
          end
        end
      end
      sync_n <= &lane_lock;
      // First K-free beat after sync marks the start of data
      rx_data_start <= sync_n && !in_data && no_k;
      if (sync_n && no_k) begin
        in_data <= 1'b1;
      end
    end
  end

  // Lane data is payload and is passed on one cycle late
  always_ff @(posedge device_clk) begin
    rx_lane_data <= rx_lane_data_in;
  end

  // The start pulse is only issued on a link that stays synchronized
  assert property (@(posedge device_clk) disable iff (reset) rx_data_start |-> sync_n)
    else $error("rx_data_start high while sync_n low");

endmodule

`default_nettype wire

// ==== logic/jesd_rx_transport.sv ====
// Receive transport layer
// Unpacks registered lane words back into the flat sample layout
// and qualifies them with a valid level

`timescale 1ns/100ps
`default_nettype none

module jesd_rx_transport import jesd_pkg::*; (
  input  logic                               device_clk,
  input  logic                               reset,
  input  logic [JESD_L-1:0][LANE_WIDTH-1:0]  rx_lane_data,
  input  logic                               rx_data_start,
  input  logic                               sync_n,
  output logic [SAMPLE_BUS_WIDTH-1:0]        rx_samples,
  output logic                               rx_valid
);

  // Valid opens on the start pulse and closes as soon as sync is lost
  always_ff @(posedge device_clk) begin
    if (reset || !sync_n) begin
      rx_valid <= 1'b0;
    end else if (rx_data_start) begin
      rx_valid <= 1'b1;
    end
  end

  // Inverse of the transmit packing, slot 0 from the low half of each lane
  always_ff @(posedge device_clk) begin
    for (int c = 0; c < JESD_M; c++) begin
      for (int s = 0; s < SAMPLES_PER_CHANNEL; s++) begin
        rx_samples[(c * SAMPLES_PER_CHANNEL + s) * JESD_NP +: JESD_NP] <=
          rx_lane_data[((c * SAMPLES_PER_CHANNEL + s) * JESD_NP) / LANE_WIDTH]
                      [((c * SAMPLES_PER_CHANNEL + s) * JESD_NP) % LANE_WIDTH +: JESD_NP];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/jesd_loopback_top.sv ====
// Top level of the converter link loopback
// Pattern source, transmit transport and link, on-chip lane loopback,
// receive link and transport, and the SYSREF to LMFC path

`timescale 1ns/100ps
`default_nettype none

module jesd_loopback_top import jesd_pkg::*; (
  input  logic                        device_clk,
  input  logic                        reset,
  input  logic                        link_enable,
  input  logic                        sysref,
  input  logic [1:0]                  sysref_sel,
  output logic                        sync_n,
  output logic                        rx_valid,
  output logic [SAMPLE_BUS_WIDTH-1:0] rx_samples
);

  logic lmfc_edge;
  logic rx_data_start;
  logic [SAMPLE_BUS_WIDTH-1:0] tx_samples;
  logic [JESD_L-1:0][LANE_WIDTH-1:0] lane_words;
  logic [JESD_L-1:0][LANE_WIDTH-1:0] tx_lane_data;
  logic [JESD_L-1:0][LANE_OCTETS-1:0] tx_lane_k;
  logic [JESD_L-1:0][LANE_WIDTH-1:0] rx_lane_data;

  sysref_lmfc u_sysref_lmfc (
    .device_clk (device_clk),
    .reset      (reset),
    .sysref     (sysref),
    .sysref_sel (sysref_sel),
    .lmfc_edge  (lmfc_edge)
  );

  sample_pattern_gen u_pattern_gen (
    .device_clk (device_clk),
    .reset      (reset),
    .samples    (tx_samples)
  );

  jesd_tx_transport u_tx_transport (
    .device_clk (device_clk),
    .reset      (reset),
    .samples    (tx_samples),
    .lane_words (lane_words)
  );

  jesd_tx_link u_tx_link (
    .device_clk   (device_clk),
    .reset        (reset),
    .lane_words   (lane_words),
    .lmfc_edge    (lmfc_edge),
    .sync_n       (sync_n),
    .tx_lane_data (tx_lane_data),
    .tx_lane_k    (tx_lane_k)
  );

  // Transmit lanes feed the receiver directly
  jesd_rx_link u_rx_link (
    .device_clk      (device_clk),
    .reset           (reset),
    .link_enable     (link_enable),
    .rx_lane_data_in (tx_lane_data),
    .rx_lane_k_in    (tx_lane_k),
    .sync_n          (sync_n),
    .rx_lane_data    (rx_lane_data),
    .rx_data_start   (rx_data_start)
  );

  jesd_rx_transport u_rx_transport (
    .device_clk    (device_clk),
    .reset         (reset),
    .rx_lane_data  (rx_lane_data),
    .rx_data_start (rx_data_start),
    .sync_n        (sync_n),
    .rx_samples    (rx_samples),
    .rx_valid      (rx_valid)
  );

endmodule

`default_nettype wire

// ==== dv/jesd_loopback_tb.sv ====
// Directed testbench for the converter link loopback
// Clock, reset, xorshift SYSREF timing and the stimulus tasks
// Sample pattern checker running on every valid beat

`timescale 1ns/100ps
`default_nettype none

module jesd_loopback_tb import jesd_pkg::*; ();

  localparam int CLK_HALF = 20;
  localparam int STIM_DELAY = 2;
  localparam int RESET_CYCLES = 8;
  localparam int MIN_BEATS = 200;
  localparam int LOCK_TIMEOUT = 100;
  localparam int VALID_TIMEOUT = 100;
  localparam int BEAT_TIMEOUT = 400;

  logic device_clk;
  logic reset;
  logic link_enable;
  logic sysref;
  logic [1:0] sysref_sel;
  logic sync_n;
  logic rx_valid;
  logic [SAMPLE_BUS_WIDTH-1:0] rx_samples;

  int cycle_cnt = 0;
  int error_count = 0;
  int timeout_count = 0;
  int valid_beats = 0;
  int last_ref = 0;
  logic have_prev = 1'b0;
  logic [7:0] prev_ramp = 8'h00;
  logic [31:0] rng_state;

  jesd_loopback_top u_dut (
    .device_clk  (device_clk),
    .reset       (reset),
    .link_enable (link_enable),
    .sysref      (sysref),
    .sysref_sel  (sysref_sel),
    .sync_n      (sync_n),
    .rx_valid    (rx_valid),
    .rx_samples  (rx_samples)
  );

  initial begin
    device_clk = 1'b0;
    forever #CLK_HALF device_clk = ~device_clk;
  end

  // Cycle n is the interval that follows rising edge n
  always @(posedge device_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ********************
  // Reporting and helpers
  // ********************

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error @ %0d ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    timeout_count++;
    $display("Timeout at %0d ns: %s", $time, msg);
  endtask

  // Inputs change and outputs are read a short delay after the rising edge
  task automatic next_cycle();
    @(posedge device_clk);
    #STIM_DELAY;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ********************
  // Pattern checker
  // ********************

  // Mid-cycle sampling sees the registered outputs settled
  always @(negedge device_clk) begin
    logic [15:0] slot0;
    logic [15:0] slot1;
    if (rx_valid !== 1'b1) begin
      have_prev = 1'b0;
    end else begin
      for (int c = 0; c < JESD_M; c++) begin
        slot0 = rx_samples[(c * SAMPLES_PER_CHANNEL) * JESD_NP +: JESD_NP];
        slot1 = rx_samples[(c * SAMPLES_PER_CHANNEL + 1) * JESD_NP +: JESD_NP];
        if (slot0[15:12] !== 4'(c) || slot1[15:12] !== 4'(c)) begin
          report_error($sformatf("channel %0d samples %h %h carry a wrong channel nibble",
                                 c, slot0, slot1));
        end
        if (slot0[11:8] !== 4'h0 || slot1[11:8] !== 4'h0) begin
          report_error($sformatf("channel %0d samples %h %h have nonzero bits 11:8",
                                 c, slot0, slot1));
        end
        // Slot 1 runs one step ahead of slot 0 in the ramp
        if (slot1[7:0] !== slot0[7:0] + 8'd1) begin
          report_error($sformatf("channel %0d slot 1 ramp %h, expected %h",
                                 c, slot1[7:0], slot0[7:0] + 8'd1));
        end
        // Each beat moves the ramp by two samples
        if (have_prev && slot0[7:0] !== prev_ramp + 8'd2) begin
          report_error($sformatf("channel %0d slot 0 ramp %h, expected %h",
                                 c, slot0[7:0], prev_ramp + 8'd2));
        end
      end
      prev_ramp = rx_samples[7:0];
      have_prev = 1'b1;
      valid_beats++;
    end
  end

  // ********************
  // Waits with timeouts
  // ********************

  task automatic wait_sync_level(input logic level);
    int n;
    n = 0;
    while (sync_n !== level && n < LOCK_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (sync_n !== level) begin
      report_timeout($sformatf("sync_n did not reach %b within %0d cycles", level, n));
    end
  endtask

  // Returns the cycle of the first valid beat, or -1 when none came
  task automatic wait_valid_rise(output int rise_cycle);
    int n;
    n = 0;
    rise_cycle = -1;
    if (rx_valid !== 1'b0) begin
      report_error($sformatf("rx_valid is %b before the link start, expected 0", rx_valid));
    end
    while (rx_valid !== 1'b1 && n < VALID_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (rx_valid === 1'b1) begin
      rise_cycle = cycle_cnt;
    end else begin
      report_timeout("rx_valid never rose after the link locked");
    end
  endtask

  task automatic wait_beats(input int count);
    int start;
    int n;
    start = valid_beats;
    n = 0;
    while (valid_beats - start < count && n < BEAT_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (valid_beats - start < count) begin
      report_timeout($sformatf("only %0d of %0d valid beats arrived", valid_beats - start, count));
    end
  endtask

  // First data lands 4 cycles after a boundary-aligned SYSREF edge, modulo the multiframe
  task automatic check_alignment(input int rise, input int ref_cycle);
    if (rise >= 0) begin
      if (rise < ref_cycle + 4 || (rise - ref_cycle - 4) % LMFC_BEATS != 0) begin
        report_error($sformatf("first rx_valid in cycle %0d, expected %0d + 8k",
                               rise, ref_cycle + 4));
      end
    end
  endtask

  task automatic drop_link();
    int n;
    link_enable = 1'b0;
    n = 0;
    while ((sync_n !== 1'b0 || rx_valid !== 1'b0) && n < LOCK_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (sync_n !== 1'b0 || rx_valid !== 1'b0) begin
      report_timeout("sync_n and rx_valid did not fall after link_enable went low");
    end
  endtask

  // ********************
  // Directed tests
  // ********************

  task automatic apply_reset();
    reset = 1'b1;
    repeat (RESET_CYCLES) begin
      next_cycle();
      if (sync_n !== 1'b0) begin
        report_error($sformatf("sync_n is %b during reset, expected 0", sync_n));
      end
      if (rx_valid !== 1'b0) begin
        report_error($sformatf("rx_valid is %b during reset, expected 0", rx_valid));
      end
    end
    reset = 1'b0;
    // The free-running LMFC starts as if SYSREF rose in the cycle before release
    last_ref = cycle_cnt - 1;
  endtask

  // Link comes up on the free-running LMFC started by reset
  task automatic link_up_test();
    int rise;
    next_cycle();
    link_enable = 1'b1;
    wait_sync_level(1'b1);
    wait_valid_rise(rise);
    check_alignment(rise, last_ref);
    wait_beats(MIN_BEATS);
  endtask

  // One SYSREF pulse at a random time with the link down, then bring the link up
  task automatic sysref_test(input logic [1:0] sel);
    int ref_cycle;
    int rise;
    drop_link();
    sysref_sel = sel;
    rng_state = xorshift32(rng_state);
    repeat (2 + rng_state % 16) next_cycle();
    sysref = 1'b1;
    ref_cycle = cycle_cnt;
    repeat (2) next_cycle();
    sysref = 1'b0;
    // Delayed sees the pulse a cycle late, inverted rises where sysref falls
    if (sel == SYSREF_DELAYED) begin
      ref_cycle = ref_cycle + 1;
    end else if (sel == SYSREF_INVERTED) begin
      ref_cycle = cycle_cnt;
    end
    repeat (3) next_cycle();
    link_enable = 1'b1;
    wait_sync_level(1'b1);
    wait_valid_rise(rise);
    check_alignment(rise, ref_cycle);
    wait_beats(MIN_BEATS);
    last_ref = ref_cycle;
  endtask

  // Relock without a new SYSREF keeps the last multiframe alignment
  task automatic relock_test();
    int rise;
    drop_link();
    repeat (5) next_cycle();
    link_enable = 1'b1;
    wait_sync_level(1'b1);
    wait_valid_rise(rise);
    check_alignment(rise, last_ref);
    wait_beats(MIN_BEATS);
  endtask

  initial begin
    reset = 1'b1;
    link_enable = 1'b0;
    sysref = 1'b0;
    sysref_sel = SYSREF_DIRECT;
    rng_state = 32'd18941;
    apply_reset();
    link_up_test();
    sysref_test(SYSREF_DIRECT);
    sysref_test(SYSREF_DELAYED);
    sysref_test(SYSREF_INVERTED);
    relock_test();
    repeat (4) next_cycle();
    $display("Valid beats: %0d, value errors: %0d, timeouts: %0d",
             valid_beats, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/jesd_pkg.sv
logic/sysref_lmfc.sv
logic/sample_pattern_gen.sv
logic/jesd_tx_transport.sv
logic/jesd_tx_link.sv
logic/jesd_rx_link.sv
logic/jesd_rx_transport.sv
logic/jesd_loopback_top.sv
dv/jesd_loopback_tb.sv

// ==== Bender.yml ====
package:
  name: jesd_loopback

sources:
  - files:
      - logic/jesd_pkg.sv
      - logic/sysref_lmfc.sv
      - logic/sample_pattern_gen.sv
      - logic/jesd_tx_transport.sv
      - logic/jesd_tx_link.sv
      - logic/jesd_rx_link.sv
      - logic/jesd_rx_transport.sv
      - logic/jesd_loopback_top.sv
  - target: test
    files:
      - dv/jesd_loopback_tb.sv
